/* source/drs_pkg.sv */
// shared DRS4 types: chip addresses, widths, control and pin structs, serial word union

package drs_pkg;

  // -------------------------------------------------------------------------
  // chip addresses and widths
  // -------------------------------------------------------------------------

  // address pin codes from the DRS4 datasheet
  typedef enum logic [3:0] {
    ADR_READ_SR  = 4'b1011,
    ADR_WRITE_SR = 4'b1101,
    ADR_CONFIG   = 4'b1100,
    ADR_STANDBY  = 4'b1111
  } drs_addr_e;

  localparam int NUM_CHANNELS   = 9;
  localparam int CHAN_BITS      = 4;
  localparam int STOP_CELL_BITS = 10;
  localparam int SHIFT_BITS     = 8;

  // bits 7..3 of the config register must always be written as one
  localparam logic [SHIFT_BITS-1:0] CONFIG_RESERVED = 8'hf8;

  // -------------------------------------------------------------------------
  // serial word, config register or write shift register pattern
  // -------------------------------------------------------------------------

  typedef struct packed {
    logic [4:0] reserved;
    logic       wsrloop;   // wsrout looped back into wsrin
    logic       pllen;
    logic       dmode;     // 1 continuous domino, 0 single shot
  } drs_config_t;

  typedef union packed {
    drs_config_t           cfg;
    logic [SHIFT_BITS-1:0] wsr_pattern;
  } drs_shift_word_u;

  // -------------------------------------------------------------------------
  // control settings and chip pins
  // -------------------------------------------------------------------------

  typedef struct packed {
    logic [9:0]              sample_count_max;  // samples per channel minus one
    logic [15:0]             wait_vdd_clocks;
    logic [7:0]              start_timer;
    logic [5:0]              adc_latency;
    logic [2:0]              srout_latency;
    logic                    dmode;
    logic                    diagnostic;        // write sample index instead of adc data
    drs_config_t             config_reg;
    logic [SHIFT_BITS-1:0]   chn_config;
    logic [NUM_CHANNELS-1:0] readout_mask;
  } drs_ctl_t;

  typedef struct packed {
    drs_addr_e addr;
    logic      nreset;
    logic      denable;   // domino wave enable
    logic      dwrite;    // connects domino wave to the sampling cells
    logic      srclk_en;
    logic      srin;
  } drs_pins_t;

  // subset driven by a serial engine
  typedef struct packed {
    drs_addr_e addr;
    logic      srclk_en;
    logic      srin;
  } drs_serial_t;

endpackage

/* source/drs_config_shifter.sv */
// serial shift-out of the config register then the write shift register, MSB first
`timescale 1ns/100ps

module drs_config_shifter (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              start_i,
  input  drs_pkg::drs_config_t              config_i,
  input  logic [drs_pkg::SHIFT_BITS-1:0]    chn_config_i,
  output drs_pkg::drs_serial_t              serial_o,
  output logic                              done_o
);
  import drs_pkg::*;

  typedef enum logic [1:0] {SH_IDLE, SH_SETUP, SH_SHIFT} shift_state_e;

  shift_state_e                  state;
  logic                          wsr_phase;   // 0 config register, 1 write shift register
  logic [$clog2(SHIFT_BITS)-1:0] bit_count;
  drs_shift_word_u               word;
  logic                          last_bit;

  assign last_bit = (state == SH_SHIFT) && (bit_count == $bits(bit_count)'(SHIFT_BITS - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= SH_IDLE;
      wsr_phase <= 1'b0;
      bit_count <= '0;
    end else begin
      unique case (state)
        SH_IDLE: begin
          if (start_i) begin
            state     <= SH_SETUP;
            wsr_phase <= 1'b0;
          end
        end
        // address setup, clock held off
        SH_SETUP: begin
          state     <= SH_SHIFT;
          bit_count <= '0;
        end
        SH_SHIFT: begin
          bit_count <= bit_count + 1'b1;
          if (last_bit) begin
            wsr_phase <= 1'b1;
            state     <= wsr_phase ? SH_IDLE : SH_SETUP;
          end
        end
        default:
          state <= SH_IDLE;
      endcase
    end
  end

  // serial word, loaded as config then as channel pattern
  always_ff @(posedge clock) begin
    if (state == SH_IDLE && start_i)
      word.cfg <= drs_config_t'(config_i | CONFIG_RESERVED);
    else if (last_bit && !wsr_phase)
      word.wsr_pattern <= chn_config_i;
    else if (state == SH_SHIFT)
      word.wsr_pattern <= word.wsr_pattern << 1;
  end

  always_comb begin
    serial_o.addr     = wsr_phase ? ADR_WRITE_SR : ADR_CONFIG;
    serial_o.srclk_en = (state == SH_SHIFT);
    serial_o.srin     = (state == SH_SHIFT) && word.wsr_pattern[SHIFT_BITS-1];
  end

  assign done_o = last_bit && wsr_phase;

  // no serial clock until a start
  assert property (@(posedge clock) disable iff (reset)
    (state == SH_IDLE && !start_i) |=> !serial_o.srclk_en)
    else $error("serial clock while shifter idle");

endmodule

/* source/drs_channel_select.sv */
// mask based channel order with first, next and last channel priority encoders
`timescale 1ns/100ps

module drs_channel_select (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [drs_pkg::NUM_CHANNELS-1:0]  mask_i,
  input  logic                              load_i,
  input  logic                              advance_i,
  output logic [drs_pkg::CHAN_BITS-1:0]     chan_addr_o,
  output logic                              first_o,
  output logic                              on_last_o
);
  import drs_pkg::*;

  logic [NUM_CHANNELS-1:0] mask_q;       // mask of this readout
  logic [NUM_CHANNELS-1:0] remaining;    // channels not yet read
  logic [NUM_CHANNELS-1:0] remaining_next;
  logic                    valid;

  // lowest set bit
  function automatic logic [CHAN_BITS-1:0] lowest_set(input logic [NUM_CHANNELS-1:0] sel);
    logic [CHAN_BITS-1:0] idx;
    idx = '0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--)
      if (sel[i])
        idx = CHAN_BITS'(i);
    return idx;
  endfunction

  // highest set bit, reverse priority
  function automatic logic [CHAN_BITS-1:0] highest_set(input logic [NUM_CHANNELS-1:0] sel);
    logic [CHAN_BITS-1:0] idx;
    idx = '0;
    for (int i = 0; i < NUM_CHANNELS; i++)
      if (sel[i])
        idx = CHAN_BITS'(i);
    return idx;
  endfunction

  assign remaining_next = remaining & ~(NUM_CHANNELS'(1) << chan_addr_o);
  assign on_last_o      = (chan_addr_o == highest_set(mask_q));

  always_ff @(posedge clock) begin
    if (reset) begin
      mask_q      <= '0;
      remaining   <= '0;
      chan_addr_o <= '0;
      first_o     <= 1'b0;
      valid       <= 1'b0;
    end else if (load_i) begin
      mask_q      <= mask_i;
      remaining   <= mask_i;
      chan_addr_o <= lowest_set(mask_i);
      first_o     <= 1'b1;
      valid       <= |mask_i;
    end else if (advance_i) begin
      // skip disabled channels
      remaining   <= remaining_next;
      chan_addr_o <= lowest_set(remaining_next);
      first_o     <= 1'b0;
      valid       <= |remaining_next;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    valid |-> (mask_q[chan_addr_o] && remaining[chan_addr_o]))
    else $error("current channel not enabled in loaded mask");

endmodule

/* source/drs_sample_capture.sv */
// per-channel readout counters, stop cell capture, ADC register and FIFO write
`timescale 1ns/100ps

module drs_sample_capture #(
  parameter int SAMPLE_WIDTH = 14
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                active_i,
  input  drs_pkg::drs_ctl_t                   ctl_i,
  input  logic                                first_chan_i,
  input  logic                                drs_srout_i,
  input  logic [SAMPLE_WIDTH-1:0]             adc_data_i,
  output logic                                srclk_en_o,
  output logic                                chan_done_o,
  output logic [SAMPLE_WIDTH-1:0]             fifo_wdata_o,
  output logic                                fifo_wen_o,
  output logic [drs_pkg::STOP_CELL_BITS-1:0]  stop_cell_o
);
  import drs_pkg::*;

  // room for sample_count_max plus adc_latency
  localparam int COUNT_BITS = 11;

  logic [COUNT_BITS-1:0]     rd_count;
  logic [9:0]                sample_count;
  logic [SAMPLE_WIDTH-1:0]   adc_q;
  logic [STOP_CELL_BITS-1:0] stop_shift;
  logic                      word_valid;
  logic                      stop_window;

  // adc data valid after the conversion latency
  assign word_valid  = active_i && (rd_count > COUNT_BITS'(ctl_i.adc_latency));
  assign chan_done_o = word_valid && (sample_count == ctl_i.sample_count_max);
  // stop cell on the first srout bits after the latency
  assign stop_window = first_chan_i &&
    (rd_count < COUNT_BITS'(ctl_i.srout_latency) + COUNT_BITS'(STOP_CELL_BITS));

  // -------------------------------------------------------------------------
  // counters and strobes
  // -------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset || !active_i) begin
      rd_count     <= '0;
      sample_count <= '0;
      srclk_en_o   <= 1'b0;
      fifo_wen_o   <= 1'b0;
    end else begin
      // sample_count_max+1 serial clocks per channel
      srclk_en_o <= (rd_count <= COUNT_BITS'(ctl_i.sample_count_max));
      fifo_wen_o <= word_valid;
      if (chan_done_o) begin
        rd_count     <= '0;
        sample_count <= '0;
      end else begin
        rd_count <= rd_count + 1'b1;
        if (word_valid)
          sample_count <= sample_count + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // data path
  // -------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    adc_q <= adc_data_i;
    // diagnostic writes the sample index
    if (ctl_i.diagnostic)
      fifo_wdata_o <= SAMPLE_WIDTH'(sample_count);
    else
      fifo_wdata_o <= adc_q;
    if (active_i && stop_window)
      stop_shift <= {stop_shift[STOP_CELL_BITS-2:0], drs_srout_i};
    if (chan_done_o && first_chan_i)
      stop_cell_o <= stop_shift;
  end

  // words land one cycle after the readout cycle that made them
  assert property (@(posedge clock) disable iff (reset)
    fifo_wen_o |-> $past(active_i))
    else $error("fifo write outside readout");

endmodule

/* source/drs_sequencer.sv */
// main readout FSM with init, start and wait-vdd timers, trigger qualify and pin drive
`timescale 1ns/100ps

module drs_sequencer (
  input  logic                           clock,
  input  logic                           reset,
  input  drs_pkg::drs_ctl_t              ctl_i,
  input  logic                           start_i,
  input  logic                           reinit_i,
  input  logic                           configure_i,
  input  logic                           trigger_i,
  input  logic                           shift_done_i,
  input  drs_pkg::drs_serial_t           serial_i,
  input  logic [drs_pkg::CHAN_BITS-1:0]  chan_addr_i,
  input  logic                           on_last_i,
  input  logic                           chan_done_i,
  input  logic                           capture_srclk_en_i,
  output logic                           shift_start_o,
  output logic                           chan_load_o,
  output logic                           capture_active_o,
  output drs_pkg::drs_pins_t             drs_pins_o,
  output logic                           readout_done_o,
  output logic                           busy_o,
  output logic                           idle_o
);
  import drs_pkg::*;

  typedef enum logic [3:0] {
    S_INIT, S_IDLE, S_CONFIGURE, S_START, S_RUNNING,
    S_TRIGGER, S_WAIT_VDD, S_READOUT, S_STOP_CELL, S_DONE
  } seq_state_e;

  seq_state_e  state;
  logic [15:0] timer;       // init, start and wait-vdd share one counter
  logic        reinit_req;
  logic        trigger_q;
  logic        nreset_q;
  logic        denable_q;
  logic        dwrite_q;
  logic        go_readout;

  // triggers only count with a nonzero mask, single shot reads back to back
  always_ff @(posedge clock) begin
    trigger_q <= trigger_i && (|ctl_i.readout_mask) && (state == S_RUNNING);
  end

  assign go_readout = trigger_q || (!ctl_i.dmode && (|ctl_i.readout_mask));

  // -------------------------------------------------------------------------
  // state machine
  // -------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= S_INIT;
      timer      <= '0;
      reinit_req <= 1'b0;
      nreset_q   <= 1'b0;
      denable_q  <= 1'b0;
      dwrite_q   <= 1'b0;
    end else begin
      // reinit pulse held until init is reached
      if (reinit_i)
        reinit_req <= 1'b1;

      unique case (state)
        S_INIT: begin
          // chip reset held two cycles
          nreset_q   <= 1'b0;
          denable_q  <= 1'b0;
          dwrite_q   <= 1'b0;
          reinit_req <= 1'b0;
          timer      <= timer + 16'd1;
          if (timer == 16'd1)
            state <= S_IDLE;
        end
        S_IDLE: begin
          nreset_q <= 1'b1;
          timer    <= '0;
          if (reinit_req)
            state <= S_INIT;
          else if (configure_i)
            state <= S_CONFIGURE;
          else if (start_i)
            state <= S_START;
        end
        S_CONFIGURE: begin
          if (shift_done_i)
            state <= S_IDLE;
        end
        S_START: begin
          // let the domino wave settle before triggers
          denable_q <= 1'b1;
          dwrite_q  <= 1'b1;
          timer     <= timer + 16'd1;
          if (reinit_req) begin
            state <= S_INIT;
            timer <= '0;
          end else if (timer == 16'(ctl_i.start_timer)) begin
            state <= S_RUNNING;
          end
        end
        S_RUNNING: begin
          timer <= '0;
          if (reinit_req) begin
            state <= S_INIT;
          end else if (go_readout) begin
            state    <= S_TRIGGER;
            dwrite_q <= 1'b0;    // stop sampling
          end
        end
        S_TRIGGER:
          state <= S_WAIT_VDD;
        S_WAIT_VDD: begin
          // supply settling after the domino stop
          timer <= timer + 16'd1;
          if (reinit_req) begin
            state <= S_INIT;
            timer <= '0;
          end else if (timer == ctl_i.wait_vdd_clocks) begin
            state <= S_READOUT;
            timer <= '0;
          end
        end
        S_READOUT: begin
          if (reinit_req)
            state <= S_INIT;
          else if (chan_done_i && on_last_i)
            state <= S_STOP_CELL;
        end
        S_STOP_CELL:
          state <= S_DONE;
        S_DONE: begin
          // restart domino, keeps the chip warm
          dwrite_q <= 1'b1;
          timer    <= '0;
          state    <= S_START;
        end
        default:
          state <= S_INIT;
      endcase
    end
  end

  assign shift_start_o    = (state == S_IDLE) && !reinit_req && configure_i;
  assign chan_load_o      = (state == S_TRIGGER);
  assign capture_active_o = (state == S_READOUT);
  assign readout_done_o   = (state == S_DONE);
  assign busy_o           = (state != S_RUNNING);
  assign idle_o           = (state == S_INIT) || (state == S_IDLE);

  // -------------------------------------------------------------------------
  // chip pins
  // -------------------------------------------------------------------------

  always_comb begin
    drs_pins_o.addr     = ADR_READ_SR;
    drs_pins_o.nreset   = nreset_q;
    drs_pins_o.denable  = denable_q;
    drs_pins_o.dwrite   = dwrite_q;
    drs_pins_o.srclk_en = 1'b0;
    drs_pins_o.srin     = 1'b0;
    case (state)
      S_INIT:
        drs_pins_o.addr = ADR_STANDBY;
      S_CONFIGURE: begin
        drs_pins_o.addr     = serial_i.addr;
        drs_pins_o.srclk_en = serial_i.srclk_en;
        drs_pins_o.srin     = serial_i.srin;
      end
      // channel address set up during wait-vdd
      S_WAIT_VDD, S_READOUT: begin
        drs_pins_o.addr     = drs_addr_e'(chan_addr_i);
        drs_pins_o.srclk_en = capture_srclk_en_i;
      end
      default: ;
    endcase
  end

  // running means domino sampling and no readout in flight
  assert property (@(posedge clock) disable iff (reset)
    !busy_o |-> (drs_pins_o.denable && drs_pins_o.dwrite && !capture_active_o))
    else $error("not busy outside of running");

  assert property (@(posedge clock) disable iff (reset)
    readout_done_o |=> !readout_done_o)
    else $error("readout done longer than one cycle");

endmodule

/* source/drs_readout.sv */
// DRS4 readout controller top level: sequencer, channel select, config shifter, sample capture
`timescale 1ns/100ps

module drs_readout #(
  parameter int SAMPLE_WIDTH = 14
) (
  input  logic                                clock,
  input  logic                                reset,
  input  drs_pkg::drs_ctl_t                   ctl_i,
  input  logic                                start_i,
  input  logic                                reinit_i,
  input  logic                                configure_i,
  input  logic                                trigger_i,
  input  logic                                drs_srout_i,
  input  logic [SAMPLE_WIDTH-1:0]             adc_data_i,
  output drs_pkg::drs_pins_t                  drs_pins_o,
  output logic [SAMPLE_WIDTH-1:0]             fifo_wdata_o,
  output logic                                fifo_wen_o,
  output logic [drs_pkg::STOP_CELL_BITS-1:0]  stop_cell_o,
  output logic                                readout_done_o,
  output logic                                busy_o,
  output logic                                idle_o
);
  import drs_pkg::*;

  // sequencer to config shifter
  logic                 shift_start;
  logic                 shift_done;
  drs_serial_t          serial;

  // channel order
  logic                 chan_load;
  logic                 chan_done;
  logic                 on_last;
  logic                 first_chan;
  logic [CHAN_BITS-1:0] chan_addr;

  // capture
  logic                 capture_active;
  logic                 capture_srclk_en;

  drs_sequencer u_sequencer (
    .clock              (clock),
    .reset              (reset),
    .ctl_i              (ctl_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .trigger_i          (trigger_i),
    .shift_done_i       (shift_done),
    .serial_i           (serial),
    .chan_addr_i        (chan_addr),
    .on_last_i          (on_last),
    .chan_done_i        (chan_done),
    .capture_srclk_en_i (capture_srclk_en),
    .shift_start_o      (shift_start),
    .chan_load_o        (chan_load),
    .capture_active_o   (capture_active),
    .drs_pins_o         (drs_pins_o),
    .readout_done_o     (readout_done_o),
    .busy_o             (busy_o),
    .idle_o             (idle_o)
  );

  drs_channel_select u_channel_select (
    .clock       (clock),
    .reset       (reset),
    .mask_i      (ctl_i.readout_mask),
    .load_i      (chan_load),
    .advance_i   (chan_done),
    .chan_addr_o (chan_addr),
    .first_o     (first_chan),
    .on_last_o   (on_last)
  );

  drs_config_shifter u_config_shifter (
    .clock        (clock),
    .reset        (reset),
    .start_i      (shift_start),
    .config_i     (ctl_i.config_reg),
    .chn_config_i (ctl_i.chn_config),
    .serial_o     (serial),
    .done_o       (shift_done)
  );

  drs_sample_capture #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) u_sample_capture (
    .clock        (clock),
    .reset        (reset),
    .active_i     (capture_active),
    .ctl_i        (ctl_i),
    .first_chan_i (first_chan),
    .drs_srout_i  (drs_srout_i),
    .adc_data_i   (adc_data_i),
    .srclk_en_o   (capture_srclk_en),
    .chan_done_o  (chan_done),
    .fifo_wdata_o (fifo_wdata_o),
    .fifo_wen_o   (fifo_wen_o),
    .stop_cell_o  (stop_cell_o)
  );

endmodule

/* test/drs_chip_model.sv */
// behavioral DRS4 and ADC model: serial write recorder, stop cell shift-out, ADC data
`timescale 1ns/100ps

module drs_chip_model #(
  parameter int SAMPLE_WIDTH = 14
) (
  input  logic                                clock,
  input  logic                                reset,
  input  drs_pkg::drs_pins_t                  pins_i,
  input  logic [drs_pkg::STOP_CELL_BITS-1:0]  stop_cell_i,
  output logic                                srout_o,
  output logic [SAMPLE_WIDTH-1:0]             adc_data_o,
  output logic [drs_pkg::SHIFT_BITS-1:0]      config_bits_o,
  output logic [drs_pkg::SHIFT_BITS-1:0]      wsr_bits_o
);
  import drs_pkg::*;

  localparam int COUNT_BITS = SAMPLE_WIDTH - CHAN_BITS;

  logic [COUNT_BITS-1:0]     read_count;    // srclk pulses since the domino stop
  logic                      read_clock;
  logic [STOP_CELL_BITS-1:0] stop_shifted;

  // readout clocks run on channel addresses, never on the register addresses
  assign read_clock = pins_i.srclk_en &&
    (pins_i.addr != ADR_CONFIG) && (pins_i.addr != ADR_WRITE_SR);

  // --------------------------------------------------------------------------
  // serial write recorder and read clock counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      config_bits_o <= '0;
      wsr_bits_o    <= '0;
      read_count    <= '0;
    end else begin
      // msb arrives first, so shift left
      if (pins_i.srclk_en && pins_i.addr == ADR_CONFIG)
        config_bits_o <= {config_bits_o[SHIFT_BITS-2:0], pins_i.srin};
      if (pins_i.srclk_en && pins_i.addr == ADR_WRITE_SR)
        wsr_bits_o <= {wsr_bits_o[SHIFT_BITS-2:0], pins_i.srin};
      // sampling clears the count
      if (pins_i.dwrite)
        read_count <= '0;
      else if (read_clock)
        read_count <= read_count + 1'b1;
    end
  end

  // stop cell msb first, one bit per read clock, zero once it is out
  assign stop_shifted = stop_cell_i << read_count;
  assign srout_o      = stop_shifted[STOP_CELL_BITS-1];

  // channel in the upper bits, clock count below
  assign adc_data_o = {pins_i.addr, read_count};

endmodule

/* test/drs_readout_tb.sv */
// testbench for the DRS4 readout controller: clock, stimulus, reference words, compare, watchdog
`timescale 1ns/100ps

module drs_readout_tb;
  import drs_pkg::*;

  localparam int SAMPLE_WIDTH = 14;
  localparam int CLK_PERIOD   = 40;
  localparam int ADC_LATENCY  = 2;
  localparam int START_TIMER  = 10;
  localparam int WAIT_VDD     = 5;
  localparam int SCM_MAX      = 23;   // largest random sample_count_max
  localparam int NUM_DIAG     = 4;
  localparam int NUM_NORMAL   = 3;
  // worst case per readout, all nine channels plus start and the way back to idle
  localparam int READOUT_CYCLES = START_TIMER + WAIT_VDD + 40 +
    NUM_CHANNELS * (ADC_LATENCY + 2 + SCM_MAX);
  localparam int TIMEOUT_CYCLES = (NUM_DIAG + NUM_NORMAL + 2) * READOUT_CYCLES + 400;

  logic                      clock = 1'b0;
  logic                      reset;
  drs_ctl_t                  ctl;
  logic                      start;
  logic                      reinit;
  logic                      configure;
  logic                      trigger;
  logic                      srout;
  logic [SAMPLE_WIDTH-1:0]   adc_data;
  drs_pins_t                 pins;
  logic [SAMPLE_WIDTH-1:0]   fifo_wdata;
  logic                      fifo_wen;
  logic [STOP_CELL_BITS-1:0] stop_cell;
  logic                      readout_done;
  logic                      busy;
  logic                      idle;
  logic [STOP_CELL_BITS-1:0] model_stop_cell;
  logic [SHIFT_BITS-1:0]     config_bits;
  logic [SHIFT_BITS-1:0]     wsr_bits;

  int                        seed = 56577;
  int                        done_count = 0;
  logic [SAMPLE_WIDTH-1:0]   exp_words[$];
  logic [SAMPLE_WIDTH-1:0]   cmp_mask;    // bits of a word that are checked

  always #(CLK_PERIOD / 2) clock = ~clock;

  drs_readout #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) uut (
    .clock          (clock),
    .reset          (reset),
    .ctl_i          (ctl),
    .start_i        (start),
    .reinit_i       (reinit),
    .configure_i    (configure),
    .trigger_i      (trigger),
    .drs_srout_i    (srout),
    .adc_data_i     (adc_data),
    .drs_pins_o     (pins),
    .fifo_wdata_o   (fifo_wdata),
    .fifo_wen_o     (fifo_wen),
    .stop_cell_o    (stop_cell),
    .readout_done_o (readout_done),
    .busy_o         (busy),
    .idle_o         (idle)
  );

  drs_chip_model #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) chip (
    .clock         (clock),
    .reset         (reset),
    .pins_i        (pins),
    .stop_cell_i   (model_stop_cell),
    .srout_o       (srout),
    .adc_data_o    (adc_data),
    .config_bits_o (config_bits),
    .wsr_bits_o    (wsr_bits)
  );

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "stopping on first mismatch");
  endtask

  // --------------------------------------------------------------------------
  // reference words and compare
  // --------------------------------------------------------------------------

  // channels ascending, sample_count_max+1 words each
  function automatic int expected_words(input logic [NUM_CHANNELS-1:0] mask,
                                        input int scm, input logic diag);
    int count;
    count = 0;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (mask[ch]) begin
        for (int s = 0; s <= scm; s++) begin
          if (diag)
            exp_words.push_back(SAMPLE_WIDTH'(s));
          else
            exp_words.push_back({CHAN_BITS'(ch), {(SAMPLE_WIDTH - CHAN_BITS){1'b0}}});
          count++;
        end
      end
    end
    return count;
  endfunction

  function automatic logic [NUM_CHANNELS-1:0] random_mask();
    logic [NUM_CHANNELS-1:0] m;
    m = NUM_CHANNELS'($random(seed));
    // an empty mask would never read out
    if (m == '0)
      m = 9'h100;
    return m;
  endfunction

  always @(negedge clock) begin
    if (!reset && fifo_wen) begin
      assert (exp_words.size() > 0)
        else report_mismatch($sformatf("unexpected fifo word %h", fifo_wdata));
      assert ((fifo_wdata & cmp_mask) == (exp_words[0] & cmp_mask))
        else report_mismatch($sformatf("fifo word %h, expected %h",
                                       fifo_wdata, exp_words[0]));
      void'(exp_words.pop_front());
    end
    if (!reset && readout_done)
      done_count = done_count + 1;
  end

  // --------------------------------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------------------------------

  // init over and chip out of reset, second idle cycle
  task automatic wait_idle();
    do @(posedge clock); while (!idle);
    do @(posedge clock); while (pins.nreset);
    do @(posedge clock); while (!pins.nreset);
  endtask

  task automatic request_reinit();
    reinit <= 1'b1;
    @(posedge clock);
    reinit <= 1'b0;
    wait_idle();
  endtask

  task automatic start_domino();
    start <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
    do @(posedge clock); while (busy);
    assert (pins.denable)
      else report_mismatch("denable low while running");
  endtask

  task automatic fire_trigger();
    trigger <= 1'b1;
    @(posedge clock);
    trigger <= 1'b0;
  endtask

  task automatic run_readout(input logic [NUM_CHANNELS-1:0] mask, input logic diag);
    int scm;
    int words;
    int done_base;
    scm = 8 + ($random(seed) & 15);
    ctl.readout_mask     <= mask;
    ctl.sample_count_max <= 10'(scm);
    ctl.diagnostic       <= diag;
    model_stop_cell      <= STOP_CELL_BITS'($random(seed));
    // normal mode only pins the channel bits
    cmp_mask = diag ? '1 : {{CHAN_BITS{1'b1}}, {(SAMPLE_WIDTH - CHAN_BITS){1'b0}}};
    words = expected_words(mask, scm, diag);
    start_domino();
    done_base = done_count;
    fire_trigger();
    do @(posedge clock); while (!readout_done);
    assert (exp_words.size() == 0)
      else report_mismatch($sformatf("%0d of %0d words missing, mask %h",
                                     exp_words.size(), words, mask));
    assert (stop_cell == model_stop_cell)
      else report_mismatch($sformatf("stop cell %h, expected %h", stop_cell, model_stop_cell));
    request_reinit();
    // no second done pulse on the way back to idle
    assert (done_count - done_base == 1)
      else report_mismatch("readout done did not pulse once");
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    reset               = 1'b1;
    start               = 1'b0;
    reinit              = 1'b0;
    configure           = 1'b0;
    trigger             = 1'b0;
    model_stop_cell     = '0;
    cmp_mask            = '1;
    ctl                 = '0;
    ctl.start_timer     = 8'(START_TIMER);
    ctl.wait_vdd_clocks = 16'(WAIT_VDD);
    ctl.adc_latency     = 6'(ADC_LATENCY);
    ctl.srout_latency   = 3'd1;
    ctl.dmode           = 1'b1;
    ctl.readout_mask    = 9'h001;
    repeat (4) @(posedge clock);
    assert (!pins.denable && !pins.srclk_en && busy)
      else report_mismatch("pins or busy wrong in reset");
    reset <= 1'b0;
    wait_idle();

    // config register then write shift register
    ctl.config_reg <= drs_config_t'(SHIFT_BITS'($random(seed)));
    ctl.chn_config <= SHIFT_BITS'($random(seed));
    configure      <= 1'b1;
    @(posedge clock);
    configure <= 1'b0;
    do @(posedge clock); while (!idle);
    assert (config_bits == (ctl.config_reg | CONFIG_RESERVED))
      else report_mismatch($sformatf("config bits %h", config_bits));
    assert (wsr_bits == ctl.chn_config)
      else report_mismatch($sformatf("write shift register bits %h", wsr_bits));

    repeat (NUM_DIAG) run_readout(random_mask(), 1'b1);
    repeat (NUM_NORMAL) run_readout(random_mask(), 1'b0);

    // empty mask ignores the trigger
    ctl.readout_mask <= '0;
    start_domino();
    fire_trigger();
    repeat (20) @(posedge clock);
    assert (!busy)
      else report_mismatch("readout started with an empty mask");

    // reinit out of running, no words after it
    request_reinit();
    repeat (20) @(posedge clock);

    $display("Testbench passed");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: controller did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* drs_readout.f */
source/drs_pkg.sv
source/drs_config_shifter.sv
source/drs_channel_select.sv
source/drs_sample_capture.sv
source/drs_sequencer.sv
source/drs_readout.sv
test/drs_chip_model.sv
test/drs_readout_tb.sv

/* run_verilator.sh */
#!/bin/sh
# build and run the DRS4 readout testbench, the exit status carries the result
verilator --binary --timing --assert -Wno-fatal --top-module drs_readout_tb \
  -f drs_readout.f -o drs_readout_sim \
  && ./obj_dir/drs_readout_sim \
  || { echo "simulation did not complete cleanly"; exit 1; }
